//--- dv/ex_checker.sv
`timescale 1ns/1ps
`default_nettype none

module ex_checker (
   input  logic                           clk,
   input  logic                           chk_en,
   // Closes the last open test
   input  logic                           chk_done,
   input  logic [15:0]                    exp_test,
   input  logic                           exp_wb_valid,
   input  logic                           exp_wb_we,
   input  logic [ncpu_cfg_pkg::dw-1:0]    exp_wb_data,
   input  logic                           exp_redirect_valid,
   input  logic [ncpu_cfg_pkg::pc_w-1:0]  exp_redirect_pc,
   // DUT outputs
   input  logic                           wb_valid,
   input  logic                           wb_we,
   input  logic [ncpu_cfg_pkg::dw-1:0]    wb_data,
   input  logic                           redirect_valid,
   input  logic [ncpu_cfg_pkg::pc_w-1:0]  redirect_pc,
   output int                             err_cnt,
   output int                             tests_run,
   output int                             tests_failed,
   output int                             checks
);

   logic [15:0]   cur_test;
   logic          in_test;
   int            test_errs;

   task automatic compare_field(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
      if (got !== exp) begin
         $display("Error: %s got %h expected %h in test %0d", name, got, exp, cur_test);
         test_errs = test_errs + 1;
         err_cnt   = err_cnt + 1;
      end
   endtask

   // One summary line per finished test
   task automatic close_test;
      tests_run = tests_run + 1;
      if (test_errs == 0) begin
         $display("Test %0d passed", cur_test);
      end else begin
         tests_failed = tests_failed + 1;
         $display("Test %0d failed with %0d errors", cur_test, test_errs);
      end
   endtask

   initial begin
      err_cnt      = 0;
      tests_run    = 0;
      tests_failed = 0;
      checks       = 0;
      test_errs    = 0;
      in_test      = 1'b0;
      cur_test     = '0;
   end

   // Mid-cycle sample with DUT outputs and expected values settled
   always @(negedge clk) begin
      if (chk_en) begin
         if (in_test && exp_test != cur_test) begin
            close_test();
         end
         if (!in_test || exp_test != cur_test) begin
            cur_test  = exp_test;
            test_errs = 0;
            in_test   = 1'b1;
         end
         checks = checks + 1;
         compare_field("wb_valid", wb_valid, exp_wb_valid);
         compare_field("wb_we", wb_we, exp_wb_we);
         compare_field("redirect_valid", redirect_valid, exp_redirect_valid);
         // Data only meaningful with a write or redirect
         if (exp_wb_we) begin
            compare_field("wb_data", wb_data, exp_wb_data);
         end
         if (exp_redirect_valid) begin
            compare_field("redirect_pc", redirect_pc, exp_redirect_pc);
         end
      end else if (chk_done && in_test) begin
         close_test();
         in_test = 1'b0;
      end
   end

endmodule

`default_nettype wire

//--- dv/ex_vectors.txt
# test valid opc pc imm operand1 operand2 rf_we, then expected wb_valid wb_we wb_data redirect_valid redirect_pc
# All hex; opc 0 add 1 sub 2 and 3 or 4 xor 5 beq 6 bne 7 bgtu 8 bgt 9 bleu a ble b jmpreg c jmprel
1 0 0 000 00000000 00000000 00000000 0  0 0 00000000 0 000
1 0 1 010 00000008 00000005 00000003 1  0 0 00000000 0 000
1 0 5 020 00000010 00000007 00000007 0  0 0 00000000 0 000
2 1 0 100 00000000 00000005 00000003 1  1 1 00000008 0 000
2 1 0 101 00000000 ffffffff 00000002 1  1 1 00000001 0 000
2 1 1 102 00000000 00000010 00000003 1  1 1 0000000d 0 000
2 1 1 103 00000000 00000000 00000001 1  1 1 ffffffff 0 000
2 1 2 104 00000000 f0f0f0f0 ff00ff00 1  1 1 f000f000 0 000
2 1 3 105 00000000 f0f0f0f0 0f0f0000 1  1 1 fffff0f0 0 000
2 1 4 106 00000000 aaaaaaaa ffff0000 1  1 1 5555aaaa 0 000
2 1 0 107 00000000 00000001 00000001 0  1 0 00000000 0 000
3 1 5 200 00000040 00000005 00000005 0  1 0 00000000 1 210
3 1 0 201 00000000 00000001 00000002 1  0 0 00000000 0 000
3 1 5 202 00000040 ffffffff 00000001 1  1 0 00000000 0 000
3 1 6 203 fffffff0 ffffffff 00000001 0  1 0 00000000 1 1ff
3 1 0 204 00000000 00000001 00000002 1  0 0 00000000 0 000
3 1 6 205 00000040 00000005 00000005 0  1 0 00000000 0 000
3 1 7 206 00000040 ffffffff 00000001 0  1 0 00000000 1 216
3 1 0 207 00000000 00000001 00000002 1  0 0 00000000 0 000
3 1 7 208 00000040 00000005 00000005 1  1 0 00000000 0 000
3 1 8 209 00000040 00000001 80000000 0  1 0 00000000 1 219
3 1 0 20a 00000000 00000001 00000002 1  0 0 00000000 0 000
3 1 8 20b 00000040 00000005 00000005 0  1 0 00000000 0 000
3 1 9 20c 00000040 00000001 80000000 0  1 0 00000000 1 21c
3 1 0 20d 00000000 00000001 00000002 1  0 0 00000000 0 000
3 1 9 20e 00000040 ffffffff 00000001 0  1 0 00000000 0 000
3 1 a 20f 00000040 ffffffff 00000001 1  1 0 00000000 1 21f
3 1 0 210 00000000 00000001 00000002 1  0 0 00000000 0 000
3 1 a 211 00000040 00000001 80000000 0  1 0 00000000 0 000
4 1 c 300 00000040 00000000 00000020 1  1 1 00000c04 1 308
4 1 0 301 00000000 00000001 00000002 1  0 0 00000000 0 000
4 1 b 302 00000040 00001000 00000000 1  1 1 00000c0c 1 400
4 1 0 303 00000000 00000001 00000002 1  0 0 00000000 0 000
4 1 c 304 00000040 00000000 fffffff8 0  1 0 00000000 1 302
4 1 0 305 00000000 00000001 00000002 1  0 0 00000000 0 000
4 1 b 306 00000040 00000abc 00000000 0  1 0 00000000 1 2af
4 1 0 307 00000000 00000001 00000002 1  0 0 00000000 0 000
5 1 5 400 00000008 00000007 00000007 0  1 0 00000000 1 402
5 1 4 401 00000000 0000ffff 000000ff 1  0 0 00000000 0 000
5 1 6 402 00000040 00000003 00000003 0  1 0 00000000 0 000
5 1 5 403 00000010 00000009 00000009 0  1 0 00000000 1 407
5 1 b 404 00000000 00000800 00000000 1  0 0 00000000 0 000
5 1 0 405 00000000 00000002 00000003 1  1 1 00000005 0 000

//--- dv/tb_ex_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ex_unit;

   localparam int reset_cycles = 10;
   // Margin before the run counts as hung
   localparam int slack_cycles = 20;

   // One vector line with stimulus then expected results
   typedef struct packed {
      logic [15:0]                     test;
      logic                            valid;
      ncpu_isa_pkg::ex_opc_e           opc;
      logic [ncpu_cfg_pkg::pc_w-1:0]   pc;
      logic [ncpu_cfg_pkg::dw-1:0]     imm;
      logic [ncpu_cfg_pkg::dw-1:0]     operand1;
      logic [ncpu_cfg_pkg::dw-1:0]     operand2;
      logic                            rf_we;
      logic                            wb_valid;
      logic                            wb_we;
      logic [ncpu_cfg_pkg::dw-1:0]     wb_data;
      logic                            redirect_valid;
      logic [ncpu_cfg_pkg::pc_w-1:0]   redirect_pc;
   } vec_t;

   logic                            clk;
   logic                            arst_n;
   logic                            valid;
   logic [3:0]                      opc;
   logic [ncpu_cfg_pkg::pc_w-1:0]   pc;
   logic [ncpu_cfg_pkg::dw-1:0]     imm;
   logic [ncpu_cfg_pkg::dw-1:0]     operand1;
   logic [ncpu_cfg_pkg::dw-1:0]     operand2;
   logic                            rf_we;
   logic                            wb_valid;
   logic                            wb_we;
   logic [ncpu_cfg_pkg::dw-1:0]     wb_data;
   logic                            redirect_valid;
   logic [ncpu_cfg_pkg::pc_w-1:0]   redirect_pc;
   // Expected values one cycle behind the stimulus
   logic                            chk_en;
   logic                            chk_done;
   vec_t                            exp_v;
   int                              err_cnt;
   int                              tests_run;
   int                              tests_failed;
   int                              checks;
   vec_t                            vecs [$];
   int                              limit = 0;
   int                              cycles = 0;

   always #50 clk = ~clk;

   ex_unit i_ex_unit (
      .clk            (clk),
      .arst_n         (arst_n),
      .valid          (valid),
      .opc            (opc),
      .pc             (pc),
      .imm            (imm),
      .operand1       (operand1),
      .operand2       (operand2),
      .rf_we          (rf_we),
      .wb_valid       (wb_valid),
      .wb_we          (wb_we),
      .wb_data        (wb_data),
      .redirect_valid (redirect_valid),
      .redirect_pc    (redirect_pc)
   );

   ex_checker i_ex_checker (
      .clk                (clk),
      .chk_en             (chk_en),
      .chk_done           (chk_done),
      .exp_test           (exp_v.test),
      .exp_wb_valid       (exp_v.wb_valid),
      .exp_wb_we          (exp_v.wb_we),
      .exp_wb_data        (exp_v.wb_data),
      .exp_redirect_valid (exp_v.redirect_valid),
      .exp_redirect_pc    (exp_v.redirect_pc),
      .wb_valid           (wb_valid),
      .wb_we              (wb_we),
      .wb_data            (wb_data),
      .redirect_valid     (redirect_valid),
      .redirect_pc        (redirect_pc),
      .err_cnt            (err_cnt),
      .tests_run          (tests_run),
      .tests_failed       (tests_failed),
      .checks             (checks)
   );

   // Parse the vector file and skip lines starting with #
   task automatic load_vectors(output bit ok);
      int            fd;
      int            n;
      bit            bad;
      string         line;
      logic [31:0]   f [0:12];
      vec_t          v;
      ok = 1'b0;
      bad = 1'b0;
      fd = $fopen("dv/ex_vectors.txt", "r");
      if (fd == 0) begin
         $display("Could not open the vector file dv/ex_vectors.txt");
      end else begin
         while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() > 0 && line[0] != "#") begin
               n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h", f[0], f[1],
                           f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11], f[12]);
               if (n == 13) begin
                  v.test           = f[0][15:0];
                  v.valid          = f[1][0];
                  // Raw opcode number from the file
                  v.opc            = ncpu_isa_pkg::ex_opc_e'(f[2][3:0]);
                  v.pc             = f[3][ncpu_cfg_pkg::pc_w-1:0];
                  v.imm            = f[4];
                  v.operand1       = f[5];
                  v.operand2       = f[6];
                  v.rf_we          = f[7][0];
                  v.wb_valid       = f[8][0];
                  v.wb_we          = f[9][0];
                  v.wb_data        = f[10];
                  v.redirect_valid = f[11][0];
                  v.redirect_pc    = f[12][ncpu_cfg_pkg::pc_w-1:0];
                  vecs.push_back(v);
               end else if (n > 0) begin
                  $display("Vector line with %0d of 13 fields: %s", n, line);
                  bad = 1'b1;
               end
            end
         end
         $fclose(fd);
         ok = !bad && (vecs.size() > 0);
      end
   endtask

   task automatic apply_inputs(input vec_t v);
      valid    <= v.valid;
      opc      <= v.opc;
      pc       <= v.pc;
      imm      <= v.imm;
      operand1 <= v.operand1;
      operand2 <= v.operand2;
      rf_we    <= v.rf_we;
   endtask

   // Hung run guard
   always @(posedge clk) begin
      cycles = cycles + 1;
      if (limit > 0 && cycles > limit) begin
         $display("Timeout: the run did not finish within %0d cycles", limit);
         $display("*** FAILED ***");
         $finish;
      end
   end

   initial begin
      bit ok;
      int i;
      clk      = 1'b0;
      arst_n   = 1'b0;
      valid    = 1'b0;
      opc      = '0;
      pc       = '0;
      imm      = '0;
      operand1 = '0;
      operand2 = '0;
      rf_we    = 1'b0;
      chk_en   = 1'b0;
      chk_done = 1'b0;
      exp_v    = '0;
      load_vectors(ok);
      if (!ok) begin
         $display("No usable vectors were read, nothing to run");
         $display("*** FAILED ***");
         $finish;
      end else begin
         limit = vecs.size() + reset_cycles + slack_cycles;
         repeat (reset_cycles) @(posedge clk);
         arst_n <= 1'b1;
         for (i = 0; i < vecs.size(); i++) begin
            @(posedge clk);
            apply_inputs(vecs[i]);
            // Previous line commits at this edge
            if (i > 0) begin
               chk_en <= 1'b1;
               exp_v  <= vecs[i-1];
            end
         end
         @(posedge clk);
         valid  <= 1'b0;
         chk_en <= 1'b1;
         exp_v  <= vecs[vecs.size()-1];
         @(posedge clk);
         chk_en   <= 1'b0;
         chk_done <= 1'b1;
         @(posedge clk);
         $display("Tests: %0d run, %0d passed, %0d failed, %0d errors in %0d checks",
                  tests_run, tests_run - tests_failed, tests_failed, err_cnt, checks);
         if (err_cnt == 0 && tests_failed == 0 && checks == vecs.size()) begin
            $display("*** PASSED ***");
         end else begin
            if (checks != vecs.size()) begin
               $display("Only %0d of %0d vector lines were checked", checks, vecs.size());
            end
            $display("*** FAILED ***");
         end
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- hdl/ex_alu.sv
`timescale 1ns/1ps
`default_nettype none

module ex_alu (
   ex_issue_if.sink                     issue,
   output logic [ncpu_cfg_pkg::dw-1:0]  alu_result,
   // Flags for branch resolution
   output logic [ncpu_cfg_pkg::dw-1:0]  add_sum,
   output logic                         add_carry,
   output logic                         add_overflow
);

   localparam int msb = ncpu_cfg_pkg::dw - 1;

   logic                          do_sub;
   logic [ncpu_cfg_pkg::dw-1:0]   op2_eff;
   logic [ncpu_cfg_pkg::dw:0]     sum_ext;

   // Branches compare by subtracting operand2 from operand1
   assign do_sub = (issue.opc == ncpu_isa_pkg::op_sub) |
                   ncpu_isa_pkg::is_bcc(issue.opc);

   // Two's complement negate by inverting here and carrying in below
   assign op2_eff = do_sub ? ~issue.operand2 : issue.operand2;

   // One extra bit keeps the carry out
   assign sum_ext = {1'b0, issue.operand1} +
                    {1'b0, op2_eff} +
                    (ncpu_cfg_pkg::dw + 1)'(do_sub);

   assign add_sum   = sum_ext[msb:0];
   // Set on subtract when there is no borrow and operand1 >= operand2 unsigned
   assign add_carry = sum_ext[ncpu_cfg_pkg::dw];

   // Same-sign inputs giving a different-sign sum
   assign add_overflow = (issue.operand1[msb] == op2_eff[msb]) &
                         (add_sum[msb] != issue.operand1[msb]);

   always_comb begin
      case (issue.opc)
         ncpu_isa_pkg::op_add,
         ncpu_isa_pkg::op_sub: begin
            alu_result = add_sum;
         end
         ncpu_isa_pkg::op_and: begin
            alu_result = issue.operand1 & issue.operand2;
         end
         ncpu_isa_pkg::op_or: begin
            alu_result = issue.operand1 | issue.operand2;
         end
         ncpu_isa_pkg::op_xor: begin
            alu_result = issue.operand1 ^ issue.operand2;
         end
         // Result unused by commit for branches and jumps
         default: begin
            alu_result = add_sum;
         end
      endcase
   end

endmodule

`default_nettype wire

//--- hdl/ex_bru.sv
`timescale 1ns/1ps
`default_nettype none

module ex_bru (
   ex_issue_if.sink                       issue,
   // Subtract result and flags from the ALU
   input  logic [ncpu_cfg_pkg::dw-1:0]    add_sum,
   input  logic                           add_carry,
   input  logic                           add_overflow,
   output logic                           b_taken,
   output logic [ncpu_cfg_pkg::pc_w-1:0]  b_tgt,
   output logic                           b_lnk
);

   localparam int msb = ncpu_cfg_pkg::dw - 1;
   localparam int lo  = ncpu_cfg_pkg::insn_len;
   localparam int hi  = ncpu_cfg_pkg::aw - 1;

   logic   cmp_eq;
   logic   cmp_lt_s;
   logic   cmp_lt_u;
   logic   bcc_taken;
   logic   jump;

   // Equality straight from the operands
   assign cmp_eq   = (issue.operand1 == issue.operand2);
   // Sign of difference corrected for overflow
   assign cmp_lt_s = add_sum[msb] ^ add_overflow;
   // Borrow out of the subtract
   assign cmp_lt_u = ~add_carry;

   assign jump = ncpu_isa_pkg::is_jump(issue.opc);

   // Branch conditions
   always_comb begin
      case (issue.opc)
         ncpu_isa_pkg::op_beq:  bcc_taken = cmp_eq;
         ncpu_isa_pkg::op_bne:  bcc_taken = ~cmp_eq;
         ncpu_isa_pkg::op_bgtu: bcc_taken = ~cmp_lt_u & ~cmp_eq;
         ncpu_isa_pkg::op_bgt:  bcc_taken = ~cmp_lt_s & ~cmp_eq;
         ncpu_isa_pkg::op_bleu: bcc_taken = cmp_lt_u | cmp_eq;
         ncpu_isa_pkg::op_ble:  bcc_taken = cmp_lt_s | cmp_eq;
         default:               bcc_taken = 1'b0;
      endcase
   end

   // Jumps are always taken
   assign b_taken = issue.valid & (bcc_taken | jump);

   // Byte offsets become word offsets by dropping the low bits
   always_comb begin
      case (issue.opc)
         // Absolute target without an alignment check on operand1
         ncpu_isa_pkg::op_jmpreg: begin
            b_tgt = issue.operand1[hi:lo];
         end
         // PC-relative by register offset
         ncpu_isa_pkg::op_jmprel: begin
            b_tgt = issue.pc + issue.operand2[hi:lo];
         end
         // Conditional branches use the immediate
         default: begin
            b_tgt = issue.pc + issue.imm[hi:lo];
         end
      endcase
   end

   // Link only for jumps that write a register
   assign b_lnk = jump & issue.rf_we;

   // ALU flags must agree with direct compares of the operands
   always_comb begin
      if (issue.valid && ncpu_isa_pkg::is_bcc(issue.opc)) begin
         a_flags_match: assert #0 (
            (cmp_lt_u == (issue.operand1 < issue.operand2)) &&
            (cmp_lt_s == ($signed(issue.operand1) < $signed(issue.operand2))));
      end
   end

endmodule

`default_nettype wire

//--- hdl/ex_commit.sv
`timescale 1ns/1ps
`default_nettype none

module ex_commit (
   input  logic                           clk,
   input  logic                           arst_n,
   ex_issue_if.sink                       issue,
   input  logic [ncpu_cfg_pkg::dw-1:0]    alu_result,
   input  logic                           b_taken,
   input  logic [ncpu_cfg_pkg::pc_w-1:0]  b_tgt,
   input  logic                           b_lnk,
   output logic                           wb_valid,
   output logic                           wb_we,
   output logic [ncpu_cfg_pkg::dw-1:0]    wb_data,
   output logic                           redirect_valid,
   output logic [ncpu_cfg_pkg::pc_w-1:0]  redirect_pc
);

   logic                             shadow_q;
   logic                             live;
   logic                             we_nxt;
   logic [ncpu_cfg_pkg::pc_w-1:0]    lnk_pc;
   logic [ncpu_cfg_pkg::dw-1:0]      data_nxt;

   // Instruction in the branch shadow is dropped
   assign live = issue.valid & ~shadow_q;

   // Return address is the next instruction
   assign lnk_pc = issue.pc + ncpu_cfg_pkg::pc_w'(1);

   // Register write source per opcode class
   always_comb begin
      if (ncpu_isa_pkg::is_alu(issue.opc)) begin
         we_nxt = issue.rf_we;
      end else if (ncpu_isa_pkg::is_jump(issue.opc)) begin
         we_nxt = b_lnk;
      end else begin
         // Conditional branches never write
         we_nxt = 1'b0;
      end
   end

   // Link value goes back out as a byte address
   assign data_nxt = ncpu_isa_pkg::is_jump(issue.opc) ?
                     ncpu_cfg_pkg::dw'({lnk_pc, {ncpu_cfg_pkg::insn_len{1'b0}}}) :
                     alu_result;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         shadow_q       <= 1'b0;
         wb_valid       <= 1'b0;
         wb_we          <= 1'b0;
         wb_data        <= '0;
         redirect_valid <= 1'b0;
         redirect_pc    <= '0;
      end else begin
         // Only a committed taken branch opens a shadow
         shadow_q       <= live & b_taken;
         wb_valid       <= live;
         wb_we          <= live & we_nxt;
         redirect_valid <= live & b_taken;
         if (live) begin
            wb_data     <= data_nxt;
         end
         if (live & b_taken) begin
            redirect_pc <= b_tgt;
         end
      end
   end

   // A link write only comes with a taken jump
   a_link_taken: assert property (
      @(posedge clk) disable iff (!arst_n)
      issue.valid && b_lnk |-> b_taken
   );

endmodule

`default_nettype wire

//--- hdl/ex_issue_if.sv
`timescale 1ns/1ps
`default_nettype none

interface ex_issue_if;

   // Instruction present this cycle
   logic                             valid;
   ncpu_isa_pkg::ex_opc_e            opc;
   // Word address of the instruction
   logic [ncpu_cfg_pkg::pc_w-1:0]    pc;
   // Byte offset for conditional branches
   logic [ncpu_cfg_pkg::dw-1:0]      imm;
   logic [ncpu_cfg_pkg::dw-1:0]      operand1;
   logic [ncpu_cfg_pkg::dw-1:0]      operand2;
   // Decoder asked for a register write
   logic                             rf_we;

   // Issue side, driven from the top level ports
   modport source (
      output valid, opc, pc, imm, operand1, operand2, rf_we
   );

   // Execute blocks only observe the instruction
   modport sink (
      input  valid, opc, pc, imm, operand1, operand2, rf_we
   );

endinterface

`default_nettype wire

//--- hdl/ex_unit.sv
`timescale 1ns/1ps
`default_nettype none

module ex_unit (
   input  logic                           clk,
   input  logic                           arst_n,
   // Issued instruction
   input  logic                           valid,
   input  logic [3:0]                     opc,
   input  logic [ncpu_cfg_pkg::pc_w-1:0]  pc,
   input  logic [ncpu_cfg_pkg::dw-1:0]    imm,
   input  logic [ncpu_cfg_pkg::dw-1:0]    operand1,
   input  logic [ncpu_cfg_pkg::dw-1:0]    operand2,
   input  logic                           rf_we,
   // Writeback one cycle later
   output logic                           wb_valid,
   output logic                           wb_we,
   output logic [ncpu_cfg_pkg::dw-1:0]    wb_data,
   // Fetch redirect
   output logic                           redirect_valid,
   output logic [ncpu_cfg_pkg::pc_w-1:0]  redirect_pc
);

   logic [ncpu_cfg_pkg::dw-1:0]     alu_result;
   logic [ncpu_cfg_pkg::dw-1:0]     add_sum;
   logic                            add_carry;
   logic                            add_overflow;
   logic                            b_taken;
   logic [ncpu_cfg_pkg::pc_w-1:0]   b_tgt;
   logic                            b_lnk;

   ex_issue_if i_issue ();

   // Issue side of the bus fed from the ports
   assign i_issue.valid    = valid;
   assign i_issue.opc      = ncpu_isa_pkg::ex_opc_e'(opc);
   assign i_issue.pc       = pc;
   assign i_issue.imm      = imm;
   assign i_issue.operand1 = operand1;
   assign i_issue.operand2 = operand2;
   assign i_issue.rf_we    = rf_we;

   ex_alu i_ex_alu (
      .issue        (i_issue.sink),
      .alu_result   (alu_result),
      .add_sum      (add_sum),
      .add_carry    (add_carry),
      .add_overflow (add_overflow)
   );

   ex_bru i_ex_bru (
      .issue        (i_issue.sink),
      .add_sum      (add_sum),
      .add_carry    (add_carry),
      .add_overflow (add_overflow),
      .b_taken      (b_taken),
      .b_tgt        (b_tgt),
      .b_lnk        (b_lnk)
   );

   // Only clocked block of the stage
   ex_commit i_ex_commit (
      .clk            (clk),
      .arst_n         (arst_n),
      .issue          (i_issue.sink),
      .alu_result     (alu_result),
      .b_taken        (b_taken),
      .b_tgt          (b_tgt),
      .b_lnk          (b_lnk),
      .wb_valid       (wb_valid),
      .wb_we          (wb_we),
      .wb_data        (wb_data),
      .redirect_valid (redirect_valid),
      .redirect_pc    (redirect_pc)
   );

endmodule

`default_nettype wire

//--- hdl/ncpu_cfg_pkg.sv
`default_nettype none

package ncpu_cfg_pkg;

   // Datapath width of the execute stage
   localparam int dw = 32;

   // Byte address width
   localparam int aw = 32;

   // Log2 of instruction size in bytes
   // Four-byte instructions, so two low address bits are always zero
   localparam int insn_len = 2;

   // PC counts words, not bytes
   localparam int pc_w = aw - insn_len;

endpackage

`default_nettype wire

//--- hdl/ncpu_isa_pkg.sv
`default_nettype none

package ncpu_isa_pkg;

   // Execute opcodes
   // Values are fixed since the vector file carries them as raw numbers
   typedef enum logic [3:0] {
      op_add    = 4'd0,
      op_sub    = 4'd1,
      op_and    = 4'd2,
      op_or     = 4'd3,
      op_xor    = 4'd4,
      op_beq    = 4'd5,
      op_bne    = 4'd6,
      op_bgtu   = 4'd7,
      op_bgt    = 4'd8,
      op_bleu   = 4'd9,
      op_ble    = 4'd10,
      op_jmpreg = 4'd11,
      op_jmprel = 4'd12
   } ex_opc_e;

   // Conditional branches resolved from the compare flags
   function automatic logic is_bcc(ex_opc_e opc);
      return opc inside {op_beq, op_bne, op_bgtu, op_bgt, op_bleu, op_ble};
   endfunction

   // Unconditional jumps by register or PC-relative offset
   function automatic logic is_jump(ex_opc_e opc);
      return opc inside {op_jmpreg, op_jmprel};
   endfunction

   // Opcodes whose result comes from the ALU
   function automatic logic is_alu(ex_opc_e opc);
      return opc inside {op_add, op_sub, op_and, op_or, op_xor};
   endfunction

endpackage

`default_nettype wire

//--- src.f
hdl/ncpu_cfg_pkg.sv
hdl/ncpu_isa_pkg.sv
hdl/ex_issue_if.sv
hdl/ex_alu.sv
hdl/ex_bru.sv
hdl/ex_commit.sv
hdl/ex_unit.sv
dv/ex_checker.sv
dv/tb_ex_unit.sv
